//--- hdl/axi_bram_defines.svh
`ifndef AXI_BRAM_DEFINES_SVH
`define AXI_BRAM_DEFINES_SVH

// --------------------------------------------------
//  axi side
// --------------------------------------------------
`define AXI_ID_BITS     8       // transaction id width
`define AXI_ADDR_BITS   12      // byte address, 4 KiB window
`define AXI_DATA_BITS   32      // one word per beat

// --------------------------------------------------
//  ram side
// --------------------------------------------------
`define RAM_ADDR_BITS   10      // 1024 words
`define RAM_RD_LATENCY  2       // array reg plus output reg

// return fifo entries, sized to cover the ram latency plus one
`define RRET_DEPTH      4

`endif

//--- hdl/axi_bram_pkg.sv
`include "axi_bram_defines.svh"

package axi_bram_pkg;

    // --------------------------------------------------
    //  vector types
    // --------------------------------------------------
    typedef logic [`AXI_ID_BITS-1:0]     axi_id_t;      // echoed on b and r
    typedef logic [`AXI_ADDR_BITS-1:0]   axi_addr_t;    // byte address
    typedef logic [`AXI_DATA_BITS-1:0]   axi_data_t;
    typedef logic [`AXI_DATA_BITS/8-1:0] axi_strb_t;    // one bit per byte
    typedef logic [7:0]                  axi_len_t;     // beats minus one
    typedef logic [`RAM_ADDR_BITS-1:0]   ram_addr_t;    // word address
    typedef logic [1:0]                  axi_resp_t;

    localparam axi_resp_t resp_okay = 2'b00;             // only response given

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        st_idle,                        // aw/ar open
        st_write,                       // taking w beats
        st_wresp,                       // b pending
        st_read                         // issuing ram reads
    } seq_state_e;

    // --------------------------------------------------
    //  channel payloads
    // --------------------------------------------------
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_burst_e burst;
    } axi_addr_req_t;

    typedef struct packed {
        axi_data_t  data;
        axi_strb_t  strb;
        logic       last;
    } axi_wbeat_t;

    typedef struct packed {
        axi_id_t    id;
        axi_data_t  data;
        axi_resp_t  resp;
        logic       last;
    } axi_rbeat_t;

    typedef struct packed {
        logic       en;                 // access this cycle
        axi_strb_t  strb;               // nonzero means write
        ram_addr_t  addr;
        axi_data_t  wdata;
    } ram_cmd_t;

    typedef struct packed {
        axi_id_t    id;
        logic       last;
    } rtag_t;

endpackage

//--- hdl/axi_burst_seq.sv
module axi_burst_seq
    import axi_bram_pkg::*;
(
    input  logic          aclk,
    input  logic          reset,
    input  axi_addr_req_t aw,
    input  logic          awvalid,
    output logic          awready,
    input  axi_wbeat_t    w,
    input  logic          wvalid,
    output logic          wready,
    output axi_id_t       bid,
    output axi_resp_t     bresp,
    output logic          bvalid,
    input  logic          bready,
    input  axi_addr_req_t ar,
    input  logic          arvalid,
    output logic          arready,
    input  ram_addr_t     cur_addr,
    input  logic          cur_last,
    output logic          load,
    output axi_addr_req_t load_req,
    output logic          advance,
    output ram_cmd_t      ram_cmd,
    input  logic          rret_space,
    output logic          rtag_valid,
    output rtag_t         rtag
);

    seq_state_e state;
    seq_state_e state_nxt;
    axi_id_t    req_id;                     // id of the burst in progress
    logic       aw_go;
    logic       ar_go;
    logic       w_go;
    logic       issue;                      // one read beat to the ram

    // --------------------------------------------------
    //  handshakes
    // --------------------------------------------------
    assign awready = (state == st_idle);
    assign arready = (state == st_idle) && !awvalid;   // aw wins a tie
    assign wready  = (state == st_write);
    assign bvalid  = (state == st_wresp);
    assign bid     = req_id;
    assign bresp   = resp_okay;

    assign aw_go = awvalid && awready;
    assign ar_go = arvalid && arready;
    assign w_go  = wvalid && wready;
    assign issue = (state == st_read) && rret_space;   // stall on full return path

    // counter control
    assign load     = aw_go || ar_go;
    assign load_req = aw_go ? aw : ar;
    assign advance  = w_go || issue;        // one step per beat

    // tag rides beside the read
    assign rtag_valid = issue;
    assign rtag       = '{id: req_id, last: cur_last};

    always_comb begin
        ram_cmd.en    = w_go || issue;
        ram_cmd.strb  = w_go ? w.strb : '0;    // reads carry no strobe
        ram_cmd.addr  = cur_addr;
        ram_cmd.wdata = w.data;
    end

    // --------------------------------------------------
    //  state machine
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (aw_go) begin
                    state_nxt = st_write;
                end else if (ar_go) begin
                    state_nxt = st_read;
                end
            end
            st_write: begin
                if (w_go && w.last) begin
                    state_nxt = st_wresp;
                end
            end
            st_wresp: begin
                if (bready) begin
                    state_nxt = st_idle;
                end
            end
            st_read: begin
                if (issue && cur_last) begin
                    state_nxt = st_idle;   // tail drains on its own
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            req_id <= load_req.id;          // held for b or r
        end
    end

endmodule

//--- hdl/axi_burst_addr.sv
module axi_burst_addr
    import axi_bram_pkg::*;
(
    input  logic          aclk,
    input  logic          reset,
    input  logic          load,
    input  axi_addr_req_t load_req,
    input  logic          advance,
    output ram_addr_t     cur_addr,
    output logic          cur_last
);

    ram_addr_t  addr_q;                     // current word address
    ram_addr_t  addr_inc;
    ram_addr_t  addr_nxt;
    ram_addr_t  wrap_mask;                  // window size minus one
    axi_len_t   len_q;
    axi_len_t   beat_q;                     // beats already taken
    axi_burst_e burst_q;

    // --------------------------------------------------
    //  next address
    // --------------------------------------------------
    assign wrap_mask = ram_addr_t'(len_q);   // len+1 is a power of two
    assign addr_inc  = addr_q + 1'b1;

    always_comb begin
        case (burst_q)
            burst_fixed: addr_nxt = addr_q;
            burst_wrap:  addr_nxt = (addr_q & ~wrap_mask) | (addr_inc & wrap_mask);
            default:     addr_nxt = addr_inc;   // incr
        endcase
    end

    // --------------------------------------------------
    //  counter registers
    // --------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            addr_q  <= '0;
            len_q   <= '0;
            beat_q  <= '0;
            burst_q <= burst_fixed;
        end else if (load) begin
            addr_q  <= ram_addr_t'(load_req.addr >> 2);  // byte to word
            len_q   <= load_req.len;
            beat_q  <= '0;
            burst_q <= load_req.burst;
        end else if (advance) begin
            addr_q  <= addr_nxt;
            beat_q  <= beat_q + 1'b1;
        end
    end

    assign cur_addr = addr_q;
    assign cur_last = (beat_q == len_q);     // final beat of the burst

endmodule

//--- hdl/bram_byte_ram.sv
`include "axi_bram_defines.svh"

module bram_byte_ram
    import axi_bram_pkg::*;
(
    input  logic      aclk,
    input  ram_cmd_t  cmd,
    output axi_data_t rdata
);

    localparam int WORDS = 1 << `RAM_ADDR_BITS;

    axi_data_t mem [WORDS];
    axi_data_t rd_q;                        // first read stage

    // array starts out zero
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // --------------------------------------------------
    //  array port
    // --------------------------------------------------
    always_ff @(posedge aclk) begin
        if (cmd.en) begin
            if (|cmd.strb) begin
                for (int b = 0; b < $bits(axi_strb_t); b++) begin
                    if (cmd.strb[b]) begin
                        mem[cmd.addr][b*8 +: 8] <= cmd.wdata[b*8 +: 8];  // byte lane
                    end
                end
            end else begin
                rd_q <= mem[cmd.addr];      // read only, no change on write
            end
        end
    end

    // output register, second cycle of latency
    always_ff @(posedge aclk) begin
        rdata <= rd_q;
    end

endmodule

//--- hdl/axi_read_return.sv
`include "axi_bram_defines.svh"

module axi_read_return
    import axi_bram_pkg::*;
(
    input  logic       aclk,
    input  logic       reset,
    input  logic       rtag_valid,
    input  rtag_t      rtag,
    input  axi_data_t  rdata,
    output logic       rret_space,
    output axi_rbeat_t r,
    output logic       rvalid,
    input  logic       rready
);

    localparam int LAT      = `RAM_RD_LATENCY;
    localparam int DEPTH    = `RRET_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + LAT + 1);

    logic [LAT-1:0]      vld_q;             // reads in flight
    rtag_t               tag_q [LAT];
    axi_rbeat_t          fifo_mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] fill;              // fifo entries
    logic [CNT_BITS-1:0] in_flight;
    logic                push;
    logic                pop;

    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // --------------------------------------------------
    //  tag pipe, matches ram latency
    // --------------------------------------------------
    always_ff @(posedge aclk) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[LAT-2:0], rtag_valid};
        end
    end

    always_ff @(posedge aclk) begin
        tag_q[0] <= rtag;
        for (int i = 1; i < LAT; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
    end

    always_comb begin
        in_flight = '0;
        for (int i = 0; i < LAT; i++) begin
            in_flight = in_flight + CNT_BITS'(vld_q[i]);
        end
    end

    // room for one more issue, counting what is already on the way
    assign rret_space = (fill + in_flight) < CNT_BITS'(DEPTH);

    // --------------------------------------------------
    //  return fifo
    // --------------------------------------------------
    assign push = vld_q[LAT-1];             // data and tag aligned here
    assign pop  = rvalid && rready;

    always_ff @(posedge aclk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= '{id: tag_q[LAT-1].id, data: rdata,
                                  resp: resp_okay, last: tag_q[LAT-1].last};
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            fill <= fill + CNT_BITS'(push) - CNT_BITS'(pop);
        end
    end

    assign rvalid = (fill != '0);
    assign r      = fifo_mem[rd_ptr];       // head of queue

endmodule

//--- hdl/axi_bram_top.sv
module axi_bram_top
    import axi_bram_pkg::*;
(
    input  logic          aclk,
    input  logic          reset,
    input  axi_addr_req_t aw,
    input  logic          awvalid,
    output logic          awready,
    input  axi_wbeat_t    w,
    input  logic          wvalid,
    output logic          wready,
    output axi_id_t       bid,
    output axi_resp_t     bresp,
    output logic          bvalid,
    input  logic          bready,
    input  axi_addr_req_t ar,
    input  logic          arvalid,
    output logic          arready,
    output axi_rbeat_t    r,
    output logic          rvalid,
    input  logic          rready
);

    // --------------------------------------------------
    //  internal links
    // --------------------------------------------------
    logic          load;
    axi_addr_req_t load_req;                // aw or ar, whichever won
    logic          advance;
    ram_addr_t     cur_addr;
    logic          cur_last;
    ram_cmd_t      ram_cmd;
    axi_data_t     ram_rdata;               // two cycles after the read
    logic          rret_space;
    logic          rtag_valid;
    rtag_t         rtag;

    axi_burst_seq u_burst_seq (
        .aclk       (aclk),
        .reset      (reset),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .bid        (bid),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .cur_addr   (cur_addr),
        .cur_last   (cur_last),
        .load       (load),
        .load_req   (load_req),
        .advance    (advance),
        .ram_cmd    (ram_cmd),
        .rret_space (rret_space),
        .rtag_valid (rtag_valid),
        .rtag       (rtag)
    );

    axi_burst_addr u_burst_addr (
        .aclk       (aclk),
        .reset      (reset),
        .load       (load),
        .load_req   (load_req),
        .advance    (advance),
        .cur_addr   (cur_addr),
        .cur_last   (cur_last)
    );

    bram_byte_ram u_ram (
        .aclk       (aclk),
        .cmd        (ram_cmd),
        .rdata      (ram_rdata)
    );

    axi_read_return u_read_return (
        .aclk       (aclk),
        .reset      (reset),
        .rtag_valid (rtag_valid),
        .rtag       (rtag),
        .rdata      (ram_rdata),
        .rret_space (rret_space),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready)
    );

endmodule

//--- sim/axi_bram_sva.sv
module axi_bram_sva
    import axi_bram_pkg::*;
(
    input logic          aclk,
    input logic          reset,
    input logic          wready,
    input axi_id_t       bid,
    input axi_resp_t     bresp,
    input logic          bvalid,
    input logic          bready,
    input axi_addr_req_t ar,
    input logic          arvalid,
    input logic          arready,
    input axi_rbeat_t    r,
    input logic          rvalid,
    input logic          rready
);

    int         fail_count = 0;
    axi_len_t   len_mem [4];                        // lens of open read bursts
    logic [1:0] len_wr;
    logic [1:0] len_rd;
    logic [2:0] len_cnt;
    axi_len_t   beat_cnt;                           // beat within current burst
    logic       ar_go;
    logic       r_go;
    logic       r_done;

    assign ar_go  = arvalid && arready;
    assign r_go   = rvalid && rready;
    assign r_done = r_go && r.last;

    always_ff @(posedge aclk) begin
        if (reset) begin
            len_wr   <= '0;
            len_rd   <= '0;
            len_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            if (ar_go) begin
                len_mem[len_wr] <= ar.len;
                len_wr          <= len_wr + 1'b1;
            end
            if (r_done) begin
                len_rd   <= len_rd + 1'b1;
                beat_cnt <= '0;
            end else if (r_go) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            len_cnt <= len_cnt + 3'(ar_go) - 3'(r_done);
        end
    end

    // --------------------------------------------------
    //  properties
    // --------------------------------------------------
    b_hold: assert property (@(posedge aclk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
        else begin
            $error("B channel changed before bready");
            fail_count++;
        end

    r_hold: assert property (@(posedge aclk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(r))
        else begin
            $error("R channel changed before rready");
            fail_count++;
        end

    idle_after_reset: assert property (@(posedge aclk)
        reset |=> !wready && !bvalid && !rvalid)
        else begin
            $error("wready, bvalid or rvalid high right after reset");
            fail_count++;
        end

    b_okay: assert property (@(posedge aclk) disable iff (reset)
        bvalid |-> bresp == resp_okay)
        else begin
            $error("bresp is not OKAY");
            fail_count++;
        end

    r_okay: assert property (@(posedge aclk) disable iff (reset)
        rvalid |-> r.resp == resp_okay)
        else begin
            $error("rresp is not OKAY");
            fail_count++;
        end

    // rlast only on beat len, and no beat without an open burst
    r_last_beat: assert property (@(posedge aclk) disable iff (reset)
        r_go |-> len_cnt != 0 && r.last == (beat_cnt == len_mem[len_rd]))
        else begin
            $error("rlast not on the final beat of its burst");
            fail_count++;
        end

endmodule

bind axi_bram_top axi_bram_sva sva_inst (
    .aclk    (aclk),
    .reset   (reset),
    .wready  (wready),
    .bid     (bid),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .ar      (ar),
    .arvalid (arvalid),
    .arready (arready),
    .r       (r),
    .rvalid  (rvalid),
    .rready  (rready)
);

//--- sim/tb_axi_bram.sv
`include "axi_bram_defines.svh"

module tb_axi_bram
    import axi_bram_pkg::*;
();

    localparam int TIMEOUT = 200;                   // cycles per wait
    localparam int WORDS   = 1 << `RAM_ADDR_BITS;

    logic          aclk = 1'b0;
    logic          reset;
    axi_addr_req_t aw;
    logic          awvalid;
    logic          awready;
    axi_wbeat_t    w;
    logic          wvalid;
    logic          wready;
    axi_id_t       bid;
    axi_resp_t     bresp;
    logic          bvalid;
    logic          bready;
    axi_addr_req_t ar;
    logic          arvalid;
    logic          arready;
    axi_rbeat_t    r;
    logic          rvalid;
    logic          rready = 1'b1;

    axi_data_t     shadow [WORDS];                  // expected ram contents
    axi_data_t     wr_data [16];                    // beats of the next write
    axi_strb_t     wr_strb [16];
    axi_rbeat_t    exp_q [$];                       // r beats still owed
    logic [31:0]   lfsr = 32'd74589;
    logic          rand_rready = 1'b0;
    int            errors = 0;
    int            checks = 0;

    always #5 aclk = ~aclk;

    axi_bram_top axi_bram_top_inst (.*);

    // --------------------------------------------------
    //  helpers
    // --------------------------------------------------
    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;   // galois step
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic axi_addr_req_t make_req(axi_id_t id_v, axi_addr_t addr_v,
                                               axi_len_t len_v, axi_burst_e burst_v);
        return '{id: id_v, addr: addr_v, len: len_v, burst: burst_v};
    endfunction

    // word touched by beat i under the axi burst rules
    function automatic ram_addr_t beat_word(axi_addr_req_t q, int i);
        int start;
        int n;
        int base;
        start = q.addr / 4;
        n     = q.len + 1;
        base  = (start / n) * n;                    // aligned wrap window
        case (q.burst)
            burst_fixed: return ram_addr_t'(start);
            burst_wrap:  return ram_addr_t'(base + (start - base + i) % n);
            default:     return ram_addr_t'(start + i);
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_run();
        int sva_errors;
        sva_errors = axi_bram_top_inst.sva_inst.fail_count;
        $display("checks %0d, check errors %0d, assertion errors %0d",
                 checks, errors, sva_errors);
        if (errors == 0 && sva_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic give_up(string what);
        errors++;
        $display("timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
        end_run();
    endtask

    task automatic fill_beats();
        for (int i = 0; i < 16; i++) begin
            wr_data[i] = take_bits(32);
            wr_strb[i] = 4'hf;                      // full word by default
        end
    endtask

    // --------------------------------------------------
    //  axi master tasks entered just after a rising edge
    // --------------------------------------------------
    task automatic send_aw(input axi_addr_req_t q);
        int n;
        aw      <= q;
        awvalid <= 1'b1;
        n = 0;
        @(negedge aclk);
        while (!awready) begin
            n++;
            if (n > TIMEOUT) give_up("awready");
            @(negedge aclk);
        end
        @(posedge aclk);                            // aw taken here
        awvalid <= 1'b0;
    endtask

    task automatic send_ar(input axi_addr_req_t q);
        int n;
        ar      <= q;
        arvalid <= 1'b1;
        n = 0;
        @(negedge aclk);
        while (!arready) begin
            n++;
            if (n > TIMEOUT) give_up("arready");
            @(negedge aclk);
        end
        @(posedge aclk);
        arvalid <= 1'b0;
    endtask

    task automatic write_burst(input axi_addr_req_t q);
        int n;
        ram_addr_t a;
        send_aw(q);
        for (int i = 0; i <= q.len; i++) begin
            w      <= '{data: wr_data[i], strb: wr_strb[i], last: (i == q.len)};
            wvalid <= 1'b1;
            n = 0;
            @(negedge aclk);
            while (!wready) begin
                n++;
                if (n > TIMEOUT) give_up("wready");
                @(negedge aclk);
            end
            @(posedge aclk);                        // beat written
            a = beat_word(q, i);
            for (int b = 0; b < 4; b++) begin
                if (wr_strb[i][b]) begin
                    shadow[a][b*8 +: 8] = wr_data[i][b*8 +: 8];
                end
            end
        end
        wvalid <= 1'b0;
        n = 0;
        @(negedge aclk);
        while (!bvalid) begin
            n++;
            if (n > TIMEOUT) give_up("bvalid");
            @(negedge aclk);
        end
        check_value("bid", bid, q.id);
        @(posedge aclk);                            // b waits one cycle on low bready
        bready <= 1'b1;
        @(posedge aclk);                            // b taken here
        bready <= 1'b0;
    endtask

    // queues the expected beats, then leaves the data to the r monitor
    task automatic read_burst(input axi_addr_req_t q);
        axi_rbeat_t e;
        for (int i = 0; i <= q.len; i++) begin
            e = '{id: q.id, data: shadow[beat_word(q, i)], resp: resp_okay,
                  last: (i == q.len)};
            exp_q.push_back(e);
        end
        send_ar(q);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            n++;
            if (n > TIMEOUT) give_up("read data");
            @(posedge aclk);
        end
    endtask

    // --------------------------------------------------
    //  r channel monitor and rready
    // --------------------------------------------------
    always @(negedge aclk) begin
        axi_rbeat_t e;
        if (!reset && rvalid && rready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("an R beat arrived with no read outstanding at %0t", $time);
            end else begin
                e = exp_q.pop_front();
                check_value("rdata", r.data, e.data);
                check_value("rid", r.id, e.id);
                check_value("rlast", r.last, e.last);
            end
        end
    end

    always @(posedge aclk) begin
        if (rand_rready) begin
            rready <= (take_bits(1) != 0);          // low about half the time
        end else begin
            rready <= 1'b1;
        end
    end

    // --------------------------------------------------
    //  sequence
    // --------------------------------------------------
    initial begin
        reset   = 1'b1;
        aw      = '0;
        awvalid = 1'b0;
        w       = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        ar      = '0;
        arvalid = 1'b0;
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = '0;                         // ram starts cleared
        end
        repeat (2) @(posedge aclk);
        reset <= 1'b0;
        @(negedge aclk);
        check_value("awready", awready, 1);
        check_value("arready", arready, 1);
        check_value("wready", wready, 0);
        check_value("bvalid", bvalid, 0);
        check_value("rvalid", rvalid, 0);
        @(posedge aclk);

        fill_beats();                               // incr write and readback
        write_burst(make_req(8'h11, 12'h000, 8'd3, burst_incr));
        read_burst(make_req(8'h12, 12'h000, 8'd3, burst_incr));
        wait_drain();

        fill_beats();                               // partial strobes
        wr_strb[0] = 4'b0100;
        wr_strb[1] = 4'b0010;
        write_burst(make_req(8'h21, 12'h004, 8'd1, burst_incr));
        read_burst(make_req(8'h22, 12'h004, 8'd1, burst_incr));
        wait_drain();

        read_burst(make_req(8'h31, 12'h004, 8'd3, burst_wrap));   // words 1 2 3 0
        wait_drain();

        fill_beats();                               // fixed burst where the last beat wins
        write_burst(make_req(8'h41, 12'h020, 8'd3, burst_fixed));
        read_burst(make_req(8'h42, 12'h020, 8'd0, burst_incr));
        read_burst(make_req(8'h43, 12'h01c, 8'd0, burst_incr));
        read_burst(make_req(8'h44, 12'h024, 8'd0, burst_incr));
        wait_drain();

        fill_beats();                               // long burst under back-pressure
        write_burst(make_req(8'h51, 12'h100, 8'd15, burst_incr));
        rand_rready <= 1'b1;
        read_burst(make_req(8'h52, 12'h100, 8'd15, burst_incr));
        read_burst(make_req(8'h53, 12'h100, 8'd7, burst_incr));
        read_burst(make_req(8'h54, 12'h108, 8'd3, burst_wrap));
        wait_drain();
        rand_rready <= 1'b0;

        repeat (4) @(posedge aclk);
        end_run();
    end

endmodule

//--- all.f
+incdir+hdl
hdl/axi_bram_pkg.sv
hdl/axi_burst_seq.sv
hdl/axi_burst_addr.sv
hdl/bram_byte_ram.sv
hdl/axi_read_return.sv
hdl/axi_bram_top.sv
sim/axi_bram_sva.sv
sim/tb_axi_bram.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := tb_axi_bram
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG) && echo "run ok" || \
		{ echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
